//--- hw/eth_loop_pkg.sv
// Shared widths, frame lengths and timing constants for the Ethernet loopback core
package eth_loop_pkg;

    // GMII byte lane
    localparam int DATA_W = 8;

    // Frames shorter than this are padded on transmit
    localparam int MIN_FRAME_LEN = 64;

    // Idle cycles enforced between transmitted frames
    localparam int IFG_CYCLES = 12;

    // Per-port frame buffer
    localparam int FIFO_DEPTH = 256;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // Fill value for padding bytes
    localparam logic [DATA_W-1:0] PAD_BYTE = '0;

endpackage

//--- hw/gmii_rx_framer.sv
// GMII receive framer that registers the byte lane and flags frame end and errors
module gmii_rx_framer
    import eth_loop_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    // GMII receive
    input  wire logic [DATA_W-1:0] gmii_rxd,
    input  wire logic              gmii_rx_dv,
    input  wire logic              gmii_rx_er,

    // Byte stream towards the frame FIFO
    output logic      [DATA_W-1:0] in_data,
    output logic                   in_valid,
    output logic                   in_last,
    output logic                   in_bad
);

// Error seen on any byte of the current frame so far
logic err_acc;

// Byte lane delayed by one stage
always_ff @(posedge clk) begin
    in_data <= gmii_rxd;
end

always_ff @(posedge clk) begin
    if (rst) begin
        in_valid <= 1'b0;
        err_acc  <= 1'b0;
    end else begin
        in_valid <= gmii_rx_dv;
        if (gmii_rx_dv) begin
            // A new frame starts with a clean error flag
            err_acc <= (in_valid ? err_acc : 1'b0) | gmii_rx_er;
        end
    end
end

// The registered byte is the last one when rx_dv has just dropped
assign in_last = in_valid && !gmii_rx_dv;
assign in_bad  = in_last && err_acc;

endmodule

//--- hw/frame_fifo.sv
// Byte frame FIFO that commits good frames and rolls back bad or overflowing ones
module frame_fifo
    import eth_loop_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
)
(
    input  wire logic              clk,
    input  wire logic              rst,

    // Write side from the receive framer
    input  wire logic [DATA_W-1:0] in_data,
    input  wire logic              in_valid,
    input  wire logic              in_last,
    input  wire logic              in_bad,

    // Read side towards the transmit shaper
    output logic      [DATA_W-1:0] out_data,
    output logic                   out_valid,
    output logic                   out_last,
    input  wire logic              out_ready,

    output logic                   frame_commit
);

localparam int ADDR_W = $clog2(DEPTH);

// Each entry holds the last flag above the data byte
logic [DATA_W:0] mem [DEPTH];

// Pointers carry one extra bit to tell full from empty
logic [ADDR_W:0] wr_ptr;
logic [ADDR_W:0] wr_commit;
logic [ADDR_W:0] rd_ptr;
logic [ADDR_W:0] wr_ptr_next;

logic drop;
logic full;
logic avail;
logic load;

assign wr_ptr_next = wr_ptr + (ADDR_W + 1)'(1);
assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
              (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

// Only committed bytes may be read
assign avail = rd_ptr != wr_commit;
assign load  = (!out_valid || out_ready) && avail;

always_ff @(posedge clk) begin
    if (in_valid && !drop && !full) begin
        mem[wr_ptr[ADDR_W-1:0]] <= {in_last, in_data};
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr       <= '0;
        wr_commit    <= '0;
        drop         <= 1'b0;
        frame_commit <= 1'b0;
    end else begin
        frame_commit <= 1'b0;
        if (in_valid) begin
            if (drop) begin
                // Skip the tail of a frame that already overflowed
                if (in_last) begin
                    drop <= 1'b0;
                end
            end else if (full) begin
                wr_ptr <= wr_commit;
                drop   <= !in_last;
            end else if (in_last) begin
                if (in_bad) begin
                    wr_ptr <= wr_commit;
                end else begin
                    wr_ptr       <= wr_ptr_next;
                    wr_commit    <= wr_ptr_next;
                    frame_commit <= 1'b1;
                end
            end else begin
                wr_ptr <= wr_ptr_next;
            end
        end
    end
end

// Output register refills whenever it is empty or being taken
always_ff @(posedge clk) begin
    if (rst) begin
        rd_ptr    <= '0;
        out_valid <= 1'b0;
    end else if (!out_valid || out_ready) begin
        out_valid <= avail;
        if (avail) begin
            rd_ptr <= rd_ptr + (ADDR_W + 1)'(1);
        end
    end
end

always_ff @(posedge clk) begin
    if (load) begin
        {out_last, out_data} <= mem[rd_ptr[ADDR_W-1:0]];
    end
end

endmodule

//--- hw/gmii_tx_shaper.sv
// GMII transmit shaper that pads short frames and enforces the inter-frame gap
module gmii_tx_shaper
    import eth_loop_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    // Frame stream from the FIFO
    input  wire logic [DATA_W-1:0] out_data,
    input  wire logic              out_valid,
    input  wire logic              out_last,
    output logic                   out_ready,

    // GMII transmit
    output logic      [DATA_W-1:0] gmii_txd,
    output logic                   gmii_tx_en,
    output logic                   gmii_tx_er
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_PAD,
    ST_GAP
} state_t;

state_t state;

// Counts bytes sent in the frame and idle cycles in the gap
logic [FIFO_ADDR_W-1:0] cnt;
logic [FIFO_ADDR_W-1:0] cnt_inc;
logic                   xfer;

assign cnt_inc   = cnt + FIFO_ADDR_W'(1);
assign out_ready = (state == ST_IDLE) || (state == ST_DATA);
assign xfer      = out_valid && out_ready;

// No error symbols are ever generated
assign gmii_tx_er = 1'b0;

always_ff @(posedge clk) begin
    if (xfer) begin
        gmii_txd <= out_data;
    end else if (state == ST_PAD) begin
        gmii_txd <= PAD_BYTE;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        state      <= ST_IDLE;
        cnt        <= '0;
        gmii_tx_en <= 1'b0;
    end else begin
        case (state)
            ST_IDLE, ST_DATA: begin
                gmii_tx_en <= xfer;
                if (xfer) begin
                    if (out_last) begin
                        if (cnt < FIFO_ADDR_W'(MIN_FRAME_LEN - 1)) begin
                            cnt   <= cnt_inc;
                            state <= ST_PAD;
                        end else begin
                            cnt   <= '0;
                            state <= ST_GAP;
                        end
                    end else begin
                        state <= ST_DATA;
                        // Saturates once no padding can be needed
                        if (cnt < FIFO_ADDR_W'(MIN_FRAME_LEN - 1)) begin
                            cnt <= cnt_inc;
                        end
                    end
                end
            end
            ST_PAD: begin
                gmii_tx_en <= 1'b1;
                if (cnt == FIFO_ADDR_W'(MIN_FRAME_LEN - 1)) begin
                    cnt   <= '0;
                    state <= ST_GAP;
                end else begin
                    cnt <= cnt_inc;
                end
            end
            ST_GAP: begin
                gmii_tx_en <= 1'b0;
                if (cnt == FIFO_ADDR_W'(IFG_CYCLES - 1)) begin
                    cnt   <= '0;
                    state <= ST_IDLE;
                end else begin
                    cnt <= cnt_inc;
                end
            end
            default: begin
                gmii_tx_en <= 1'b0;
                state      <= ST_IDLE;
            end
        endcase
    end
end

endmodule

//--- hw/port_loopback.sv
// Single Ethernet port loop from GMII receive through the frame FIFO back to transmit
module port_loopback
    import eth_loop_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire logic [DATA_W-1:0] gmii_rxd,
    input  wire logic              gmii_rx_dv,
    input  wire logic              gmii_rx_er,

    output wire logic [DATA_W-1:0] gmii_txd,
    output wire logic              gmii_tx_en,
    output wire logic              gmii_tx_er,

    output logic                   led
);

logic [DATA_W-1:0] in_data;
logic              in_valid;
logic              in_last;
logic              in_bad;

logic [DATA_W-1:0] out_data;
logic              out_valid;
logic              out_last;
logic              out_ready;

logic              frame_commit;

gmii_rx_framer rx_framer_inst (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(gmii_rxd),
    .gmii_rx_dv(gmii_rx_dv),
    .gmii_rx_er(gmii_rx_er),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_last(in_last),
    .in_bad(in_bad)
);

frame_fifo #(
    .DEPTH(FIFO_DEPTH)
)
frame_fifo_inst (
    .clk(clk),
    .rst(rst),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_last(in_last),
    .in_bad(in_bad),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_last(out_last),
    .out_ready(out_ready),
    .frame_commit(frame_commit)
);

gmii_tx_shaper tx_shaper_inst (
    .clk(clk),
    .rst(rst),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_last(out_last),
    .out_ready(out_ready),
    .gmii_txd(gmii_txd),
    .gmii_tx_en(gmii_tx_en),
    .gmii_tx_er(gmii_tx_er)
);

// Toggle per forwarded frame
always_ff @(posedge clk) begin
    if (rst) begin
        led <= 1'b0;
    end else if (frame_commit) begin
        led <= !led;
    end
end

endmodule

//--- hw/fpga_core.sv
// FPGA core with two independent GMII loopback ports and the PHY reset outputs
module fpga_core
    import eth_loop_pkg::*;
(
    // 125 MHz, synchronous reset
    input  wire logic              clk,
    input  wire logic              rst,

    output wire logic [1:0]        led,

    // Ethernet port 2
    input  wire logic [DATA_W-1:0] phy2_gmii_rxd,
    input  wire logic              phy2_gmii_rx_dv,
    input  wire logic              phy2_gmii_rx_er,
    output wire logic [DATA_W-1:0] phy2_gmii_txd,
    output wire logic              phy2_gmii_tx_en,
    output wire logic              phy2_gmii_tx_er,
    output wire logic              phy2_reset_n,

    // Ethernet port 3
    input  wire logic [DATA_W-1:0] phy3_gmii_rxd,
    input  wire logic              phy3_gmii_rx_dv,
    input  wire logic              phy3_gmii_rx_er,
    output wire logic [DATA_W-1:0] phy3_gmii_txd,
    output wire logic              phy3_gmii_tx_en,
    output wire logic              phy3_gmii_tx_er,
    output wire logic              phy3_reset_n
);

// PHYs stay in reset with the core
assign phy2_reset_n = !rst;
assign phy3_reset_n = !rst;

port_loopback phy2_loop_inst (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(phy2_gmii_rxd),
    .gmii_rx_dv(phy2_gmii_rx_dv),
    .gmii_rx_er(phy2_gmii_rx_er),
    .gmii_txd(phy2_gmii_txd),
    .gmii_tx_en(phy2_gmii_tx_en),
    .gmii_tx_er(phy2_gmii_tx_er),
    .led(led[0])
);

port_loopback phy3_loop_inst (
    .clk(clk),
    .rst(rst),
    .gmii_rxd(phy3_gmii_rxd),
    .gmii_rx_dv(phy3_gmii_rx_dv),
    .gmii_rx_er(phy3_gmii_rx_er),
    .gmii_txd(phy3_gmii_txd),
    .gmii_tx_en(phy3_gmii_tx_en),
    .gmii_tx_er(phy3_gmii_tx_er),
    .led(led[1])
);

endmodule

//--- dv/tb_frame_model.svh
// Reference model of the loopback path and the Galois LFSR used for random stimulus
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

typedef logic [DATA_W-1:0] byte_q_t [$];

// LFSR state seeded once for the whole run
logic [15:0] lfsr_state = 16'd93;

// Galois form of x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 16'hB400;
    end
    return next;
endfunction

// One LFSR step for every bit taken
function automatic int random_bits(input int n);
    int value;
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
        value = (value << 1) | int'(lfsr_state[0]);
        lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
endfunction

// Bad frames and frames that never fit the buffer vanish while short ones get padded
function automatic byte_q_t expected_frame(input byte_q_t rx_bytes, input bit had_error);
    byte_q_t tx_bytes;
    tx_bytes = {};
    if (had_error || rx_bytes.size() > FIFO_DEPTH) begin
        return tx_bytes;
    end
    tx_bytes = rx_bytes;
    while (tx_bytes.size() < MIN_FRAME_LEN) begin
        tx_bytes.push_back(PAD_BYTE);
    end
    return tx_bytes;
endfunction

`endif

//--- dv/tb_fpga_core.sv
// Testbench for the two-port GMII loopback core with directed and random frames
module tb_fpga_core
    import eth_loop_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int RESET_CYCLES = 8;

`include "tb_frame_model.svh"

logic              clk;
logic              rst;
logic [DATA_W-1:0] rxd [2];
logic              rx_dv [2];
logic              rx_er [2];
logic [DATA_W-1:0] txd [2];
logic              tx_en [2];
logic              tx_er [2];
logic [1:0]        led;
logic              phy2_reset_n;
logic              phy3_reset_n;

// Frames to send and frames expected back with index 0 for phy2
int                frm_len [2][$];
int                frm_gap [2][$];
int                frm_err [2][$];
logic [DATA_W-1:0] frm_data [2][$];
int                exp_len [2][$];
logic [DATA_W-1:0] exp_data [2][$];
int                good_frames [2];
int                led_toggles [2];
logic [1:0]        led_prev;
int                budget_cycles;
int                timeout_cycles;
int                cycle_count;

fpga_core fpga_core_inst (
    .clk(clk),
    .rst(rst),
    .led(led),
    .phy2_gmii_rxd(rxd[0]),
    .phy2_gmii_rx_dv(rx_dv[0]),
    .phy2_gmii_rx_er(rx_er[0]),
    .phy2_gmii_txd(txd[0]),
    .phy2_gmii_tx_en(tx_en[0]),
    .phy2_gmii_tx_er(tx_er[0]),
    .phy2_reset_n(phy2_reset_n),
    .phy3_gmii_rxd(rxd[1]),
    .phy3_gmii_rx_dv(rx_dv[1]),
    .phy3_gmii_rx_er(rx_er[1]),
    .phy3_gmii_txd(txd[1]),
    .phy3_gmii_tx_en(tx_en[1]),
    .phy3_gmii_tx_er(tx_er[1]),
    .phy3_reset_n(phy3_reset_n)
);

always #5 clk = !clk;

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
endtask

task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
        fail_run($sformatf("ERROR at %0t: %s expected 0x%0h, actual 0x%0h",
                           $time, name, expected, actual));
    end
endtask

// Long enough idle time that the FIFO never fills by accident
function automatic int normal_gap();
    return MIN_FRAME_LEN + IFG_CYCLES + 16 + random_bits(5);
endfunction

task automatic add_frame(input int p, input int len, input int gap, input int err_pos);
    byte_q_t rx_bytes;
    byte_q_t tx_bytes;
    int      k;
    for (k = 0; k < len; k++) begin
        rx_bytes.push_back(DATA_W'(random_bits(DATA_W)));
        frm_data[p].push_back(rx_bytes[k]);
    end
    frm_len[p].push_back(len);
    frm_gap[p].push_back(gap);
    frm_err[p].push_back(err_pos);
    tx_bytes = expected_frame(rx_bytes, err_pos >= 0);
    if (tx_bytes.size() != 0) begin
        exp_len[p].push_back(tx_bytes.size());
        foreach (tx_bytes[i]) begin
            exp_data[p].push_back(tx_bytes[i]);
        end
        good_frames[p]++;
    end
    budget_cycles += (len > MIN_FRAME_LEN ? len : MIN_FRAME_LEN) + IFG_CYCLES + gap;
endtask

// Random length with roughly one frame in eight carrying an error
task automatic add_random_frame(input int p);
    int len;
    int err_pos;
    len = 1 + random_bits(8) % 200;
    err_pos = (random_bits(3) == 0) ? random_bits(8) % len : -1;
    add_frame(p, len, normal_gap(), err_pos);
endtask

task automatic send_frames(input int p);
    int pos;
    int i;
    int j;
    pos = 0;
    for (i = 0; i < frm_len[p].size(); i++) begin
        for (j = 0; j < frm_len[p][i]; j++) begin
            @(posedge clk);
            #1;
            rxd[p]   = frm_data[p][pos];
            rx_dv[p] = 1'b1;
            rx_er[p] = (j == frm_err[p][i]);
            pos++;
        end
        for (j = 0; j < frm_gap[p][i]; j++) begin
            @(posedge clk);
            #1;
            rxd[p]   = '0;
            rx_dv[p] = 1'b0;
            rx_er[p] = 1'b0;
        end
    end
endtask

// Collects each tx_en frame and checks it against the oldest expected one
task automatic watch_port(input int p);
    byte_q_t got;
    string   port_name;
    int      idle;
    int      n;
    bit      seen;
    idle = 0;
    seen = 1'b0;
    port_name = (p == 0) ? "phy2" : "phy3";
    forever begin
        @(negedge clk);
        compare_value({port_name, "_gmii_tx_er"}, 0, tx_er[p]);
        if (tx_en[p] === 1'b1) begin
            if (got.size() == 0 && seen && idle < IFG_CYCLES) begin
                fail_run($sformatf("Only %0d idle cycles before a frame on %s at %0t",
                                   idle, port_name, $time));
            end
            got.push_back(txd[p]);
            idle = 0;
        end else begin
            if (got.size() != 0) begin
                if (exp_len[p].size() == 0) begin
                    fail_run($sformatf("Unexpected frame of %0d bytes on %s at %0t",
                                       got.size(), port_name, $time));
                end
                n = exp_len[p].pop_front();
                compare_value({port_name, " frame length"}, n, got.size());
                foreach (got[k]) begin
                    compare_value({port_name, "_gmii_txd"}, exp_data[p].pop_front(), got[k]);
                end
                got.delete();
                seen = 1'b1;
            end
            idle++;
        end
    end
endtask

// LED edges only count once reset is over
always @(negedge clk) begin
    if (rst === 1'b0) begin
        if (led[0] !== led_prev[0]) begin
            led_toggles[0]++;
        end
        if (led[1] !== led_prev[1]) begin
            led_toggles[1]++;
        end
    end
    led_prev = led;
end

always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
        fail_run($sformatf("Timeout after %0d cycles, %0d frames on phy2 and %0d on phy3 missing",
                           cycle_count, exp_len[0].size(), exp_len[1].size()));
    end
end

initial begin
    $timeformat(-9, 0, " ns", 0);
    clk = 1'b0;
    rst = 1'b1;
    for (int p = 0; p < 2; p++) begin
        rxd[p]   = '0;
        rx_dv[p] = 1'b0;
        rx_er[p] = 1'b0;
        good_frames[p] = 0;
        led_toggles[p] = 0;
    end
    led_prev = '0;
    cycle_count = 0;
    budget_cycles = 0;

    // Full-size frames followed by short ones that need padding
    repeat (4) add_frame(0, 64 + random_bits(8) % 137, normal_gap(), -1);
    add_frame(0, 1, normal_gap(), -1);
    add_frame(0, 17, normal_gap(), -1);
    add_frame(0, MIN_FRAME_LEN - 1, normal_gap(), -1);
    // Errored frame between two good ones
    add_frame(0, 100, normal_gap(), -1);
    add_frame(0, 80, normal_gap(), random_bits(8) % 80);
    add_frame(0, 40, normal_gap(), -1);
    // Back to back burst loads the FIFO while the shaper pads and waits
    add_frame(0, 20, 1, -1);
    add_frame(0, 70, 1, -1);
    add_frame(0, 30, 1, -1);
    add_frame(0, 100, 300, -1);
    // Oversized frame followed by normal traffic
    add_frame(0, 300, normal_gap(), -1);
    add_frame(0, 90, normal_gap(), -1);
    repeat (8) add_random_frame(0);
    repeat (12) add_random_frame(1);
    timeout_cycles = 2 * budget_cycles + RESET_CYCLES;

    fork
        watch_port(0);
        watch_port(1);
    join_none

    repeat (RESET_CYCLES) @(posedge clk);
    compare_value("phy2_reset_n", 0, phy2_reset_n);
    compare_value("phy3_reset_n", 0, phy3_reset_n);
    #1;
    rst = 1'b0;
    @(negedge clk);
    compare_value("phy2_reset_n", 1, phy2_reset_n);
    compare_value("phy3_reset_n", 1, phy3_reset_n);
    compare_value("led", 0, led);

    fork
        send_frames(0);
        send_frames(1);
    join
    while (exp_len[0].size() != 0 || exp_len[1].size() != 0) begin
        @(negedge clk);
    end
    compare_value("led[0] toggles", good_frames[0], led_toggles[0]);
    compare_value("led[1] toggles", good_frames[1], led_toggles[1]);
    $display("Test OK");
    $finish;
end

endmodule

//--- tb.f
+incdir+dv
hw/eth_loop_pkg.sv
hw/gmii_rx_framer.sv
hw/frame_fifo.sv
hw/gmii_tx_shaper.sv
hw/port_loopback.sv
hw/fpga_core.sv
dv/tb_fpga_core.sv

//--- Bender.yml
package:
  name: eth_loopback

sources:
  - files:
      - hw/eth_loop_pkg.sv
      - hw/gmii_rx_framer.sv
      - hw/frame_fifo.sv
      - hw/gmii_tx_shaper.sv
      - hw/port_loopback.sv
      - hw/fpga_core.sv

  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_fpga_core.sv
